/* design/eai_col_accum.sv */
// Column accumulator for colsum.
// A shift buffer of ROW_WORDS running totals fed by row reader beats;
// after a full row, entry c holds the total of column c.

`timescale 1ns/1ns
`default_nettype none

module eai_col_accum import eai_pkg::*; (
   input  logic                 eai_clk,
   input  logic                 rst_n,
   input  logic                 col_clear,
   input  logic                 beat_valid,
   input  logic [XLEN-1:0]      beat_data,
   input  logic [COL_IDX_W-1:0] col_idx,
   output logic [XLEN-1:0]      col_sum
);

   logic [XLEN-1:0]      col_buf [ROW_WORDS];
   logic                 clear_pend;
   logic [COL_IDX_W-1:0] beat_cnt;
   logic                 last_beat;
   logic [XLEN-1:0]      carry;

   assign last_beat = (beat_cnt == COL_IDX_W'(ROW_WORDS - 1));
   // oldest entry is the same column as the incoming beat
   assign carry     = clear_pend ? '0 : col_buf[0];

   always_ff @(posedge eai_clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < ROW_WORDS; i++) begin
            col_buf[i] <= '0;
         end
         clear_pend <= 1'b0;
         beat_cnt   <= '0;
      end else begin
         if (beat_valid) begin
            for (int i = 0; i < ROW_WORDS - 1; i++) begin
               col_buf[i] <= col_buf[i + 1];
            end
            col_buf[ROW_WORDS-1] <= beat_data + carry;
            beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
         end
         if (col_clear) begin
            clear_pend <= 1'b1;
         end else if (beat_valid && last_beat) begin
            clear_pend <= 1'b0;
         end
      end
   end

   assign col_sum = (col_idx < ROW_WORDS) ? col_buf[col_idx] : '0;

   a_clear_at_row_edge: assert property (
      @(posedge eai_clk) disable iff (!rst_n)
      col_clear |-> (beat_cnt == '0)
   );

endmodule

`default_nettype wire

/* design/eai_ctrl.sv */
// Controller of the matrix coprocessor.
// Decodes custom0 requests, keeps the setup registers, sequences rowsum
// through the row reader and holds the response until the core takes it.

`timescale 1ns/1ns
`default_nettype none

module eai_ctrl import eai_pkg::*; (
   input  logic                 eai_clk,
   input  logic                 rst_n,
   // core request
   input  logic                 eai_req_valid,
   output logic                 eai_req_ready,
   input  logic [XLEN-1:0]      eai_req_inst,
   input  logic [XLEN-1:0]      eai_req_rs1,
   input  logic [XLEN-1:0]      eai_req_rs2,
   // core response
   output logic                 eai_rsp_valid,
   input  logic                 eai_rsp_ready,
   output logic [XLEN-1:0]      eai_rsp_rdat,
   output logic                 eai_rsp_err,
   // row reader
   output logic                 row_start,
   output logic [ADDR_W-1:0]    row_addr,
   input  logic                 row_done,
   input  logic [XLEN-1:0]      row_sum,
   input  logic                 row_err,
   // column accumulator
   output logic                 col_clear,
   output logic [COL_IDX_W-1:0] col_idx,
   input  logic [XLEN-1:0]      col_sum
);

   logic [ST_W-1:0]   state;
   logic [ADDR_W-1:0] base_r;
   logic [XLEN-1:0]   stride_r;
   logic [XLEN-1:0]   rsp_rdat_r;
   logic              rsp_err_r;

   //////////////////////////////////////////////////
   // decode
   //////////////////////////////////////////////////
   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   logic       is_custom0;
   logic       is_setup;
   logic       is_rowsum;
   logic       is_colsum;
   logic       req_hsk;
   logic       rsp_hsk;

   assign opcode = eai_req_inst[6:0];
   assign funct3 = eai_req_inst[14:12];
   assign funct7 = eai_req_inst[31:25];

   assign is_custom0 = (opcode == OPCODE_CUSTOM0);
   assign is_setup   = is_custom0 && (funct3 == F3_SETUP) && (funct7 == F7_SETUP);
   assign is_rowsum  = is_custom0 && (funct3 == F3_SUM) && (funct7 == F7_ROWSUM);
   assign is_colsum  = is_custom0 && (funct3 == F3_SUM) && (funct7 == F7_COLSUM);

   assign req_hsk = eai_req_valid && eai_req_ready;
   assign rsp_hsk = eai_rsp_valid && eai_rsp_ready;

   //////////////////////////////////////////////////
   // state machine
   //////////////////////////////////////////////////
   always_ff @(posedge eai_clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE: begin
               if (req_hsk) begin
                  state <= is_rowsum ? ST_ROW : ST_RSP;
               end
            end
            ST_ROW: begin
               if (row_done) begin
                  state <= ST_RSP;
               end
            end
            ST_RSP: begin
               if (rsp_hsk) begin
                  state <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // setup registers and response payload
   always_ff @(posedge eai_clk) begin
      if (req_hsk && is_setup) begin
         base_r   <= eai_req_rs1;
         stride_r <= eai_req_rs2;
      end
      if (req_hsk) begin
         rsp_rdat_r <= is_colsum ? col_sum : '0;
         // anything not recognised answers with an error
         rsp_err_r  <= !(is_setup || is_rowsum || is_colsum);
      end else if ((state == ST_ROW) && row_done) begin
         rsp_rdat_r <= row_sum;
         rsp_err_r  <= row_err;
      end
   end

   //////////////////////////////////////////////////
   // row and column requests
   //////////////////////////////////////////////////
   assign row_start = req_hsk && is_rowsum;
   assign row_addr  = base_r + eai_req_rs1 * stride_r * ADDR_W'(WORD_BYTES);

   // row 0 opens a fresh set of column totals
   assign col_clear = row_start && (eai_req_rs1 == '0);

   // out of range index maps to the zero entry
   assign col_idx = (eai_req_rs1 < ROW_WORDS) ? eai_req_rs1[COL_IDX_W-1:0]
                                              : COL_IDX_W'(ROW_WORDS);

   assign eai_req_ready = (state == ST_IDLE);
   assign eai_rsp_valid = (state == ST_RSP);
   assign eai_rsp_rdat  = rsp_rdat_r;
   assign eai_rsp_err   = rsp_err_r;

   a_rsp_stable: assert property (
      @(posedge eai_clk) disable iff (!rst_n)
      (eai_rsp_valid && !eai_rsp_ready) |=>
         (eai_rsp_valid && $stable(eai_rsp_rdat) && $stable(eai_rsp_err))
   );

endmodule

`default_nettype wire

/* design/eai_pkg.sv */
// Shared constants for the matrix coprocessor on the custom0 EAI port.
// Widths, instruction encodings, row geometry and controller state codes.
// Import with a wildcard in each module header.

`default_nettype none

package eai_pkg;

   //////////////////////////////////////////////////
   // data and address widths
   //////////////////////////////////////////////////
   localparam int XLEN       = 32;
   localparam int ADDR_W     = 32;
   localparam int WORD_BYTES = 4;

   // one row is also the number of column entries
   localparam int ROW_WORDS = 3;
   localparam int COL_IDX_W = 2;

   //////////////////////////////////////////////////
   // custom0 instruction encoding
   //////////////////////////////////////////////////
   localparam logic [6:0] OPCODE_CUSTOM0 = 7'b0001011;

   localparam logic [2:0] F3_SETUP = 3'b011;
   localparam logic [2:0] F3_SUM   = 3'b110;

   localparam logic [6:0] F7_SETUP  = 7'b0000000;
   localparam logic [6:0] F7_ROWSUM = 7'b0000001;
   localparam logic [6:0] F7_COLSUM = 7'b0000010;

   //////////////////////////////////////////////////
   // controller states
   //////////////////////////////////////////////////
   localparam int ST_W = 2;

   localparam logic [ST_W-1:0] ST_IDLE = 2'd0;
   // rowsum reads in flight
   localparam logic [ST_W-1:0] ST_ROW  = 2'd1;
   localparam logic [ST_W-1:0] ST_RSP  = 2'd2;

endpackage

`default_nettype wire

/* design/eai_row_reader.sv */
// Row reader for rowsum.
// Reads ROW_WORDS consecutive words over the ICB style bus, one read at a
// time, and reports each beat plus the final sum and error OR.

`timescale 1ns/1ns
`default_nettype none

module eai_row_reader import eai_pkg::*; (
   input  logic              eai_clk,
   input  logic              rst_n,
   input  logic              row_start,
   input  logic [ADDR_W-1:0] row_addr,
   // memory command
   output logic              cmd_valid,
   input  logic              cmd_ready,
   output logic [ADDR_W-1:0] cmd_addr,
   // memory response
   input  logic              rsp_valid,
   output logic              rsp_ready,
   input  logic [XLEN-1:0]   rsp_rdata,
   input  logic              rsp_err,
   // beats and result
   output logic              beat_valid,
   output logic [XLEN-1:0]   beat_data,
   output logic              row_done,
   output logic [XLEN-1:0]   row_sum,
   output logic              row_err,
   output logic              busy
);

   logic                 cmd_valid_r;
   logic                 wait_rsp_r;
   logic                 busy_r;
   logic                 done_r;
   // word index inside the row, same as its column
   logic [COL_IDX_W-1:0] beat_cnt;
   logic [ADDR_W-1:0]    addr_r;
   logic [XLEN-1:0]      sum_r;
   logic                 err_r;

   logic cmd_hsk;
   logic rsp_hsk;
   logic last_beat;

   assign cmd_hsk   = cmd_valid_r && cmd_ready;
   assign rsp_hsk   = rsp_valid && wait_rsp_r;
   assign last_beat = (beat_cnt == COL_IDX_W'(ROW_WORDS - 1));

   //////////////////////////////////////////////////
   // sequencing
   //////////////////////////////////////////////////
   always_ff @(posedge eai_clk or negedge rst_n) begin
      if (!rst_n) begin
         cmd_valid_r <= 1'b0;
         wait_rsp_r  <= 1'b0;
         busy_r      <= 1'b0;
         done_r      <= 1'b0;
         beat_cnt    <= '0;
      end else begin
         done_r <= rsp_hsk && last_beat;
         if (row_start) begin
            cmd_valid_r <= 1'b1;
            busy_r      <= 1'b1;
            beat_cnt    <= '0;
         end else begin
            if (cmd_hsk) begin
               cmd_valid_r <= 1'b0;
               wait_rsp_r  <= 1'b1;
            end
            // next read goes out right after each response
            if (rsp_hsk) begin
               wait_rsp_r  <= 1'b0;
               cmd_valid_r <= !last_beat;
               beat_cnt    <= beat_cnt + 1'b1;
            end
            if (done_r) begin
               busy_r <= 1'b0;
            end
         end
      end
   end

   // address, sum and error
   always_ff @(posedge eai_clk) begin
      if (row_start) begin
         addr_r <= row_addr;
         sum_r  <= '0;
         err_r  <= 1'b0;
      end else if (rsp_hsk) begin
         addr_r <= addr_r + ADDR_W'(WORD_BYTES);
         sum_r  <= sum_r + rsp_rdata;
         err_r  <= err_r | rsp_err;
      end
   end

   assign cmd_valid  = cmd_valid_r;
   assign cmd_addr   = addr_r;
   assign rsp_ready  = wait_rsp_r;
   assign beat_valid = rsp_hsk;
   assign beat_data  = rsp_rdata;
   assign row_done   = done_r;
   assign row_sum    = sum_r;
   assign row_err    = err_r;
   assign busy       = busy_r;

   a_cmd_hold: assert property (
      @(posedge eai_clk) disable iff (!rst_n)
      (cmd_valid && !cmd_ready) |=> (cmd_valid && $stable(cmd_addr))
   );

endmodule

`default_nettype wire

/* design/eai_top.sv */
// Top of the matrix coprocessor on the custom0 EAI port.
// Connects the controller, the row reader and the column accumulator
// to the core request/response and memory ICB ports.

`timescale 1ns/1ns
`default_nettype none

module eai_top import eai_pkg::*; (
   input  logic              eai_clk,
   input  logic              rst_n,
   // core request
   input  logic              eai_req_valid,
   output logic              eai_req_ready,
   input  logic [XLEN-1:0]   eai_req_inst,
   input  logic [XLEN-1:0]   eai_req_rs1,
   input  logic [XLEN-1:0]   eai_req_rs2,
   // core response
   output logic              eai_rsp_valid,
   input  logic              eai_rsp_ready,
   output logic [XLEN-1:0]   eai_rsp_rdat,
   output logic              eai_rsp_err,
   output logic              eai_mem_holdup,
   // memory command
   output logic              eai_icb_cmd_valid,
   input  logic              eai_icb_cmd_ready,
   output logic [ADDR_W-1:0] eai_icb_cmd_addr,
   // memory response
   input  logic              eai_icb_rsp_valid,
   output logic              eai_icb_rsp_ready,
   input  logic [XLEN-1:0]   eai_icb_rsp_rdata,
   input  logic              eai_icb_rsp_err
);

   logic                 row_start;
   logic [ADDR_W-1:0]    row_addr;
   logic                 row_done;
   logic [XLEN-1:0]      row_sum;
   logic                 row_err;
   logic                 beat_valid;
   logic [XLEN-1:0]      beat_data;
   logic                 col_clear;
   logic [COL_IDX_W-1:0] col_idx;
   logic [XLEN-1:0]      col_sum;

   eai_ctrl i_eai_ctrl (
      .eai_clk       (eai_clk),
      .rst_n         (rst_n),
      .eai_req_valid (eai_req_valid),
      .eai_req_ready (eai_req_ready),
      .eai_req_inst  (eai_req_inst),
      .eai_req_rs1   (eai_req_rs1),
      .eai_req_rs2   (eai_req_rs2),
      .eai_rsp_valid (eai_rsp_valid),
      .eai_rsp_ready (eai_rsp_ready),
      .eai_rsp_rdat  (eai_rsp_rdat),
      .eai_rsp_err   (eai_rsp_err),
      .row_start     (row_start),
      .row_addr      (row_addr),
      .row_done      (row_done),
      .row_sum       (row_sum),
      .row_err       (row_err),
      .col_clear     (col_clear),
      .col_idx       (col_idx),
      .col_sum       (col_sum)
   );

   // busy doubles as the memory holdup toward the core
   eai_row_reader i_eai_row_reader (
      .eai_clk    (eai_clk),
      .rst_n      (rst_n),
      .row_start  (row_start),
      .row_addr   (row_addr),
      .cmd_valid  (eai_icb_cmd_valid),
      .cmd_ready  (eai_icb_cmd_ready),
      .cmd_addr   (eai_icb_cmd_addr),
      .rsp_valid  (eai_icb_rsp_valid),
      .rsp_ready  (eai_icb_rsp_ready),
      .rsp_rdata  (eai_icb_rsp_rdata),
      .rsp_err    (eai_icb_rsp_err),
      .beat_valid (beat_valid),
      .beat_data  (beat_data),
      .row_done   (row_done),
      .row_sum    (row_sum),
      .row_err    (row_err),
      .busy       (eai_mem_holdup)
   );

   eai_col_accum i_eai_col_accum (
      .eai_clk    (eai_clk),
      .rst_n      (rst_n),
      .col_clear  (col_clear),
      .beat_valid (beat_valid),
      .beat_data  (beat_data),
      .col_idx    (col_idx),
      .col_sum    (col_sum)
   );

endmodule

`default_nettype wire

/* project.f */
design/eai_pkg.sv
design/eai_ctrl.sv
design/eai_row_reader.sv
design/eai_col_accum.sv
design/eai_top.sv
test/eai_mem_model.sv
test/tb_eai_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_eai_top -Mdir obj_dir -f project.f

status=0
out="$(./obj_dir/Vtb_eai_top)" || status=$?
echo "$out"

if [ "$status" -eq 0 ] && grep -qx 'test passed' <<< "$out"; then
   exit 0
fi
exit 1

/* test/eai_mem_model.sv */
// Behavioural read memory on the ICB style bus, for the testbench only.
// Word at byte address a holds a*7+256; reads at or above ERR_ADDR flag an
// error. Command accept and response delay are random, one read at a time.

`timescale 1ns/1ns
`default_nettype none

module eai_mem_model import eai_pkg::*; #(
   parameter int          MEM_WORDS = 4096,
   parameter logic [31:0] ERR_ADDR  = 32'h3000,
   parameter logic [31:0] SEED      = 32'h56284f47
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              cmd_valid,
   output logic              cmd_ready,
   input  logic [ADDR_W-1:0] cmd_addr,
   output logic              rsp_valid,
   input  logic              rsp_ready,
   output logic [XLEN-1:0]   rsp_rdata,
   output logic              rsp_err
);

   localparam int IDX_W = $clog2(MEM_WORDS);

   logic [XLEN-1:0]   mem [MEM_WORDS];
   logic              ready_q = 1'b0;
   logic              valid_q = 1'b0;
   logic [XLEN-1:0]   rdata_q = '0;
   logic              err_q   = 1'b0;
   logic              pending = 1'b0;
   logic [1:0]        delay   = '0;
   logic [ADDR_W-1:0] addr_q  = '0;
   integer            seed    = SEED;

   initial begin
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = XLEN'(i * WORD_BYTES * 7 + 256);
      end
   end

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ready_q <= 1'b0;
         valid_q <= 1'b0;
         pending <= 1'b0;
         delay   <= '0;
      end else if (cmd_valid && ready_q) begin
         ready_q <= 1'b0;
         pending <= 1'b1;
         addr_q  <= cmd_addr;
         delay   <= 2'($random(seed));
      end else if (pending) begin
         if (delay == 2'd0) begin
            valid_q <= 1'b1;
            rdata_q <= mem[addr_q[IDX_W+1:2]];
            err_q   <= (addr_q >= ERR_ADDR);
            pending <= 1'b0;
         end else begin
            delay <= delay - 2'd1;
         end
      end else if (valid_q) begin
         if (rsp_ready) begin
            valid_q <= 1'b0;
         end
      end else begin
         // accept roughly three cycles in four
         ready_q <= (($random(seed) & 3) != 0);
      end
   end

   assign cmd_ready = ready_q;
   assign rsp_valid = valid_q;
   assign rsp_rdata = rdata_q;
   assign rsp_err   = err_q;

endmodule

`default_nettype wire

/* test/tb_eai_top.sv */
// Testbench for the matrix coprocessor top level.
// Applies a table of custom0 instructions against a random-delay memory
// model and checks each response value, its timing and its stability.

`timescale 1ns/1ns
`default_nettype none

module tb_eai_top import eai_pkg::*; ();

   localparam int          TIMEOUT   = 200;
   localparam int          MEM_WORDS = 4096;
   localparam logic [31:0] ERR_ADDR  = 32'h3000;
   localparam int          MAX_ROWS  = 32;

   logic              clk;
   logic              rst_n;
   logic              eai_req_valid;
   logic              eai_req_ready;
   logic [XLEN-1:0]   eai_req_inst;
   logic [XLEN-1:0]   eai_req_rs1;
   logic [XLEN-1:0]   eai_req_rs2;
   logic              eai_rsp_valid;
   logic              eai_rsp_ready;
   logic [XLEN-1:0]   eai_rsp_rdat;
   logic              eai_rsp_err;
   logic              eai_mem_holdup;
   logic              eai_icb_cmd_valid;
   logic              eai_icb_cmd_ready;
   logic [ADDR_W-1:0] eai_icb_cmd_addr;
   logic              eai_icb_rsp_valid;
   logic              eai_icb_rsp_ready;
   logic [XLEN-1:0]   eai_icb_rsp_rdata;
   logic              eai_icb_rsp_err;

   // stimulus table, one instruction per row
   logic [2:0]  t_f3   [MAX_ROWS];
   logic [6:0]  t_f7   [MAX_ROWS];
   logic [31:0] t_rs1  [MAX_ROWS];
   logic [31:0] t_rs2  [MAX_ROWS];
   logic [31:0] t_rdat [MAX_ROWS];
   logic        t_err  [MAX_ROWS];
   // byte address of the first word, rowsum only
   logic [31:0] t_addr [MAX_ROWS];
   int          n_rows;
   int          errors;
   int          timeouts;
   integer      seed;

   eai_top i_eai_top (
      .eai_clk           (clk),
      .rst_n             (rst_n),
      .eai_req_valid     (eai_req_valid),
      .eai_req_ready     (eai_req_ready),
      .eai_req_inst      (eai_req_inst),
      .eai_req_rs1       (eai_req_rs1),
      .eai_req_rs2       (eai_req_rs2),
      .eai_rsp_valid     (eai_rsp_valid),
      .eai_rsp_ready     (eai_rsp_ready),
      .eai_rsp_rdat      (eai_rsp_rdat),
      .eai_rsp_err       (eai_rsp_err),
      .eai_mem_holdup    (eai_mem_holdup),
      .eai_icb_cmd_valid (eai_icb_cmd_valid),
      .eai_icb_cmd_ready (eai_icb_cmd_ready),
      .eai_icb_cmd_addr  (eai_icb_cmd_addr),
      .eai_icb_rsp_valid (eai_icb_rsp_valid),
      .eai_icb_rsp_ready (eai_icb_rsp_ready),
      .eai_icb_rsp_rdata (eai_icb_rsp_rdata),
      .eai_icb_rsp_err   (eai_icb_rsp_err)
   );

   eai_mem_model #(.MEM_WORDS(MEM_WORDS), .ERR_ADDR(ERR_ADDR)) i_mem (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_valid (eai_icb_cmd_valid),
      .cmd_ready (eai_icb_cmd_ready),
      .cmd_addr  (eai_icb_cmd_addr),
      .rsp_valid (eai_icb_rsp_valid),
      .rsp_ready (eai_icb_rsp_ready),
      .rsp_rdata (eai_icb_rsp_rdata),
      .rsp_err   (eai_icb_rsp_err)
   );

   //////////////////////////////////////////////////
   // expected values from the memory rule
   //////////////////////////////////////////////////
   function automatic logic [31:0] mem_word(input logic [31:0] addr);
      return addr * 32'd7 + 32'd256;
   endfunction

   function automatic logic [31:0] row_addr_of(input logic [31:0] base, stride, row);
      return base + row * stride * 32'd4;
   endfunction

   function automatic logic [31:0] col_total(input logic [31:0] base, stride, col);
      logic [31:0] sum;
      sum = '0;
      for (int r = 0; r < ROW_WORDS; r++) begin
         sum += mem_word(row_addr_of(base, stride, r) + col * 32'd4);
      end
      return sum;
   endfunction

   function automatic logic [31:0] make_inst(input logic [2:0] f3, input logic [6:0] f7);
      return {f7, 5'd2, 5'd1, f3, 5'd10, OPCODE_CUSTOM0};
   endfunction

   task automatic add_row(input logic [2:0] f3, input logic [6:0] f7,
                          input logic [31:0] rs1, rs2, rdat, input logic err);
      t_f3[n_rows]   = f3;
      t_f7[n_rows]   = f7;
      t_rs1[n_rows]  = rs1;
      t_rs2[n_rows]  = rs2;
      t_rdat[n_rows] = rdat;
      t_err[n_rows]  = err;
      t_addr[n_rows] = '0;
      n_rows++;
   endtask

   task automatic add_rowsum(input logic [31:0] base, stride, row);
      logic [31:0] addr;
      logic [31:0] sum;
      addr = row_addr_of(base, stride, row);
      sum  = mem_word(addr) + mem_word(addr + 32'd4) + mem_word(addr + 32'd8);
      add_row(F3_SUM, F7_ROWSUM, row, '0, sum, (addr + 32'd8) >= ERR_ADDR);
      t_addr[n_rows - 1] = addr;
   endtask

   task automatic fill_table();
      n_rows = 0;
      add_row(F3_SETUP, F7_SETUP, 32'h100, 32'd4, '0, 1'b0);
      for (int r = 0; r < ROW_WORDS; r++) begin
         add_rowsum(32'h100, 32'd4, r);
      end
      for (int c = 0; c < ROW_WORDS; c++) begin
         add_row(F3_SUM, F7_COLSUM, c, '0, col_total(32'h100, 32'd4, c), 1'b0);
      end
      add_row(F3_SUM, F7_COLSUM, 32'd3, '0, '0, 1'b0);
      // row 0 again restarts the column totals
      add_rowsum(32'h100, 32'd4, 32'd0);
      add_row(F3_SUM, F7_COLSUM, 32'd1, '0, mem_word(32'h104), 1'b0);
      // rows reaching into the error region
      add_row(F3_SETUP, F7_SETUP, 32'h2ff8, 32'd5, '0, 1'b0);
      add_rowsum(32'h2ff8, 32'd5, 32'd0);
      add_rowsum(32'h2ff8, 32'd5, 32'd2);
      add_row(F3_SUM, 7'b0000011, 32'd1, '0, '0, 1'b1);
      add_row(3'b000, F7_ROWSUM, 32'd1, '0, '0, 1'b1);
      add_row(F3_SETUP, F7_SETUP, 32'h200, 32'd3, '0, 1'b0);
      add_rowsum(32'h200, 32'd3, 32'd1);
      add_row(F3_SUM, F7_COLSUM, 32'd0, '0,
              mem_word(32'h2ff8) + mem_word(32'h3020) + mem_word(32'h20c), 1'b0);
      add_row(F3_SUM, F7_COLSUM, 32'd5, '0, '0, 1'b0);
   endtask

   //////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////
   task automatic check_value(input string name, input logic [31:0] got, exp);
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic note_timeout(input string what);
      timeouts++;
      $display("Timeout at %0t ns: no %s within %0d cycles", $time, what, TIMEOUT);
   endtask

   // enters and leaves just after a rising edge
   task automatic run_entry(input int i);
      logic        is_row;
      logic        hsk;
      logic        taken;
      logic [31:0] rdat0;
      logic        err0;
      int          waited;
      int          beats;
      is_row = (t_f3[i] == F3_SUM) && (t_f7[i] == F7_ROWSUM);
      eai_req_valid <= 1'b1;
      eai_req_inst  <= make_inst(t_f3[i], t_f7[i]);
      eai_req_rs1   <= t_rs1[i];
      eai_req_rs2   <= t_rs2[i];
      hsk    = 1'b0;
      waited = 0;
      while (!hsk && waited < TIMEOUT) begin
         @(posedge clk);
         hsk = eai_req_ready;
         waited++;
      end
      eai_req_valid <= 1'b0;
      if (!hsk) begin
         note_timeout("request handshake");
         return;
      end
      @(posedge clk);
      // single cycle answer for everything but rowsum
      if (!is_row) begin
         check_value("eai_rsp_valid", eai_rsp_valid, 32'd1);
      end
      waited = 0;
      beats  = 0;
      while (!eai_rsp_valid && waited < TIMEOUT) begin
         check_value("eai_mem_holdup", eai_mem_holdup, 32'd1);
         check_value("eai_req_ready", eai_req_ready, 32'd0);
         if (eai_icb_cmd_valid && eai_icb_cmd_ready) begin
            check_value("eai_icb_cmd_addr", eai_icb_cmd_addr, t_addr[i] + beats * 32'd4);
            beats++;
         end
         @(posedge clk);
         waited++;
      end
      if (!eai_rsp_valid) begin
         note_timeout("response");
         return;
      end
      if (is_row) begin
         check_value("memory command count", beats, ROW_WORDS);
      end
      rdat0 = eai_rsp_rdat;
      err0  = eai_rsp_err;
      check_value("eai_rsp_rdat", rdat0, t_rdat[i]);
      check_value("eai_rsp_err", err0, t_err[i]);
      // payload must hold under random back-pressure
      taken  = 1'b0;
      waited = 0;
      while (!taken && waited < TIMEOUT) begin
         check_value("eai_rsp_valid", eai_rsp_valid, 32'd1);
         check_value("eai_rsp_rdat", eai_rsp_rdat, rdat0);
         check_value("eai_rsp_err", eai_rsp_err, err0);
         check_value("eai_req_ready", eai_req_ready, 32'd0);
         check_value("eai_mem_holdup", eai_mem_holdup, 32'd0);
         check_value("eai_icb_cmd_valid", eai_icb_cmd_valid, 32'd0);
         taken = eai_rsp_ready;
         if (!taken) begin
            eai_rsp_ready <= 1'($random(seed));
            @(posedge clk);
            waited++;
         end
      end
      eai_rsp_ready <= 1'b0;
      if (!taken) begin
         note_timeout("response handshake");
         return;
      end
      @(posedge clk);
      check_value("eai_req_ready", eai_req_ready, 32'd1);
      check_value("eai_rsp_valid", eai_rsp_valid, 32'd0);
   endtask

   //////////////////////////////////////////////////
   // clock, reset and main sequence
   //////////////////////////////////////////////////
   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      rst_n         = 1'b0;
      eai_req_valid = 1'b0;
      eai_req_inst  = '0;
      eai_req_rs1   = '0;
      eai_req_rs2   = '0;
      eai_rsp_ready = 1'b0;
      errors        = 0;
      timeouts      = 0;
      seed          = 32'h56284f47;
      fill_table();
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      check_value("eai_req_ready", eai_req_ready, 32'd1);
      check_value("eai_rsp_valid", eai_rsp_valid, 32'd0);
      check_value("eai_icb_cmd_valid", eai_icb_cmd_valid, 32'd0);
      check_value("eai_icb_rsp_ready", eai_icb_rsp_ready, 32'd0);
      check_value("eai_mem_holdup", eai_mem_holdup, 32'd0);
      for (int i = 0; i < n_rows && timeouts == 0; i++) begin
         run_entry(i);
      end
      $display("%0d mismatches, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
